// File: logic/afifo_pkg.sv
package afifo_pkg;

  // ####################
  // data path
  // ####################

  // width of one word in the FIFO
  parameter int data_w = 8;

  typedef logic [data_w-1:0] data_t;

  // ####################
  // status flags
  // ####################

  // write side flags, both registered in wr_clk
  typedef struct packed {
    logic full;   // no room for another word
    logic afull;  // used count at or above the almost-full level
  } wr_stat_t;

  // read side flags, both registered in rd_clk
  typedef struct packed {
    logic empty;  // nothing left to read
    logic aempty; // used count at or below the almost-empty level
  } rd_stat_t;

  // reset values of the flags
  // the write side starts with room and the read side starts with nothing to read
  parameter wr_stat_t wr_stat_rst = '{full: 1'b0, afull: 1'b0};
  parameter rd_stat_t rd_stat_rst = '{empty: 1'b1, aempty: 1'b1};

endpackage

// File: logic/afifo_dpram.sv
`timescale 1ns/10ps

module afifo_dpram #(
  parameter int depth = 16,
  localparam int addr_w = $clog2(depth)
) (
  input  logic              wr_clk,
  input  logic              wr_en,
  input  logic [addr_w-1:0] wr_addr,
  input  afifo_pkg::data_t  wr_data,
  input  logic              rd_clk,
  input  logic              rd_rst_n,
  input  logic              rd_en,
  input  logic [addr_w-1:0] rd_addr,
  output afifo_pkg::data_t  rd_data
);

  import afifo_pkg::*;

  data_t mem [depth];

  // ####################
  // write port, wr_clk
  // ####################

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ####################
  // read port, rd_clk
  // ####################

  // the output register keeps its word until the next accepted read
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// File: logic/afifo_gray_sync.sv
`timescale 1ns/10ps

module afifo_gray_sync #(
  parameter int ptr_w = 5
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [ptr_w-1:0] gray,
  output logic [ptr_w-1:0] bin
);

  logic [ptr_w-1:0] sync1;
  logic [ptr_w-1:0] sync2;
  logic [ptr_w-1:0] bin_nxt;

  // only one bit of gray changes per source step, so each flop sees a clean code
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync1 <= '0;
      sync2 <= '0;
    end else begin
      sync1 <= gray;  // may go metastable
      sync2 <= sync1;
    end
  end

  // gray to binary, each bit is the xor of all gray bits above and at it
  always_comb begin
    bin_nxt[ptr_w-1] = sync2[ptr_w-1];
    for (int i = ptr_w - 2; i >= 0; i--) begin
      bin_nxt[i] = bin_nxt[i+1] ^ sync2[i];
    end
  end

  // third stage, keeps the xor chain off the compare paths in the controllers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bin <= '0;
    end else begin
      bin <= bin_nxt;
    end
  end

endmodule

// File: logic/afifo_wr_ctrl.sv
`timescale 1ns/10ps

module afifo_wr_ctrl #(
  parameter int depth = 16,
  parameter int afull_level = 12,
  localparam int addr_w = $clog2(depth),
  localparam int ptr_w = addr_w + 1
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [ptr_w-1:0]      rd_ptr_bin,
  output logic                  wr_vld,
  output logic [addr_w-1:0]     wr_addr,
  output logic [ptr_w-1:0]      wr_ptr_gray,
  output afifo_pkg::wr_stat_t   wr_stat
);

  import afifo_pkg::*;

  // the extra top bit tells a full FIFO from an empty one
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] wr_ptr_nxt;
  logic [ptr_w-1:0] used_nxt;
  wr_stat_t         stat_nxt;

  // ####################
  // write acceptance
  // ####################

  assign wr_vld  = wr_en & ~wr_stat.full;  // writes while full are dropped
  assign wr_addr = wr_ptr[addr_w-1:0];

  assign wr_ptr_nxt = wr_ptr + ptr_w'(wr_vld);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= (wr_ptr_nxt >> 1) ^ wr_ptr_nxt;
    end
  end

  // ####################
  // flags
  // ####################

  // the read pointer lags the real one, so the count is never too low
  // and the flags err on the full side until the read reaches this domain
  assign used_nxt = wr_ptr_nxt - rd_ptr_bin;

  always_comb begin
    stat_nxt.full  = (used_nxt == ptr_w'(depth));
    stat_nxt.afull = (used_nxt >= ptr_w'(afull_level));
  end

  // full goes high on the same edge that takes the last free slot
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_stat <= wr_stat_rst;
    end else begin
      wr_stat <= stat_nxt;
    end
  end

endmodule

// File: logic/afifo_rd_ctrl.sv
`timescale 1ns/10ps

module afifo_rd_ctrl #(
  parameter int depth = 16,
  parameter int aempty_level = 2,
  localparam int addr_w = $clog2(depth),
  localparam int ptr_w = addr_w + 1
) (
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  input  logic [ptr_w-1:0]      wr_ptr_bin,
  output logic                  rd_vld,
  output logic [addr_w-1:0]     rd_addr,
  output logic [ptr_w-1:0]      rd_ptr_gray,
  output afifo_pkg::rd_stat_t   rd_stat
);

  import afifo_pkg::*;

  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w-1:0] rd_ptr_nxt;
  logic [ptr_w-1:0] used_nxt;
  rd_stat_t         stat_nxt;

  // ####################
  // read acceptance
  // ####################

  assign rd_vld  = rd_en & ~rd_stat.empty;  // reads while empty are ignored
  assign rd_addr = rd_ptr[addr_w-1:0];

  assign rd_ptr_nxt = rd_ptr + ptr_w'(rd_vld);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= (rd_ptr_nxt >> 1) ^ rd_ptr_nxt;
    end
  end

  // ####################
  // flags
  // ####################

  // the write pointer seen here is late, so the count can only be too low
  // and empty stays set until the new words are really in the memory
  assign used_nxt = wr_ptr_bin - rd_ptr_nxt;

  always_comb begin
    stat_nxt.empty  = (rd_ptr_nxt == wr_ptr_bin);
    stat_nxt.aempty = (used_nxt <= ptr_w'(aempty_level));
  end

  // empty goes high on the edge that takes the last word
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_stat <= rd_stat_rst;
    end else begin
      rd_stat <= stat_nxt;
    end
  end

endmodule

// File: logic/async_fifo.sv
`timescale 1ns/10ps

module async_fifo #(
  parameter int depth = 16,
  parameter int afull_level = 12,
  parameter int aempty_level = 2
) (
  input  logic                wr_clk,
  input  logic                wr_rst_n,
  input  logic                wr_en,
  input  afifo_pkg::data_t    wr_data,
  input  logic                rd_clk,
  input  logic                rd_rst_n,
  input  logic                rd_en,
  output afifo_pkg::data_t    rd_data,
  output afifo_pkg::wr_stat_t wr_stat,
  output afifo_pkg::rd_stat_t rd_stat
);

  localparam int addr_w = $clog2(depth);
  localparam int ptr_w  = addr_w + 1;

  logic              wr_vld;
  logic              rd_vld;
  logic [addr_w-1:0] wr_addr;
  logic [addr_w-1:0] rd_addr;
  logic [ptr_w-1:0]  wr_ptr_gray;
  logic [ptr_w-1:0]  rd_ptr_gray;
  logic [ptr_w-1:0]  wr_ptr_bin_rs;  // write pointer as seen in rd_clk
  logic [ptr_w-1:0]  rd_ptr_bin_ws;  // read pointer as seen in wr_clk

  // ####################
  // write domain
  // ####################

  afifo_wr_ctrl #(
    .depth       (depth),
    .afull_level (afull_level)
  ) u_wr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .rd_ptr_bin  (rd_ptr_bin_ws),
    .wr_vld      (wr_vld),
    .wr_addr     (wr_addr),
    .wr_ptr_gray (wr_ptr_gray),
    .wr_stat     (wr_stat)
  );

  afifo_gray_sync #(.ptr_w(ptr_w)) u_rd_ptr_sync (
    .clk   (wr_clk),
    .rst_n (wr_rst_n),
    .gray  (rd_ptr_gray),
    .bin   (rd_ptr_bin_ws)
  );

  // ####################
  // read domain
  // ####################

  afifo_rd_ctrl #(
    .depth        (depth),
    .aempty_level (aempty_level)
  ) u_rd_ctrl (
    .rd_clk       (rd_clk),
    .rd_rst_n     (rd_rst_n),
    .rd_en        (rd_en),
    .wr_ptr_bin   (wr_ptr_bin_rs),
    .rd_vld       (rd_vld),
    .rd_addr      (rd_addr),
    .rd_ptr_gray  (rd_ptr_gray),
    .rd_stat      (rd_stat)
  );

  afifo_gray_sync #(.ptr_w(ptr_w)) u_wr_ptr_sync (
    .clk   (rd_clk),
    .rst_n (rd_rst_n),
    .gray  (wr_ptr_gray),
    .bin   (wr_ptr_bin_rs)
  );

  // memory sits between the two domains
  afifo_dpram #(.depth(depth)) u_dpram (
    .wr_clk   (wr_clk),
    .wr_en    (wr_vld),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_vld),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int period_ns = 20
) (
  output logic clk
);

  // starts low so the first rising edge comes half a period in
  initial begin
    clk = 1'b0;
  end

  always #(period_ns / 2.0) clk = ~clk;

endmodule

// File: dv/async_fifo_chk.sv
`timescale 1ns/10ps

module async_fifo_chk (
  input logic                wr_clk,
  input logic                wr_rst_n,
  input logic                rd_clk,
  input logic                rd_rst_n,
  input logic                rd_en,
  input afifo_pkg::data_t    rd_data,
  input afifo_pkg::wr_stat_t wr_stat,
  input afifo_pkg::rd_stat_t rd_stat
);

  // ####################
  // write side flags
  // ####################

  // depth is never below the almost-full level
  a_full_afull : assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    wr_stat.full |-> wr_stat.afull)
    else $error("full is set while afull is clear");

  a_wr_stat_known : assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    !$isunknown(wr_stat))
    else $error("wr_stat carries an unknown value");

  // ####################
  // read side
  // ####################

  a_empty_aempty : assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_stat.empty |-> rd_stat.aempty)
    else $error("empty is set while aempty is clear");

  a_rd_stat_known : assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    !$isunknown(rd_stat))
    else $error("rd_stat carries an unknown value");

  // the output register only moves on an accepted read
  a_rd_data_hold : assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    !(rd_en && !rd_stat.empty) |=> $stable(rd_data))
    else $error("rd_data changed without an accepted read");

  a_rd_data_known : assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    (rd_en && !rd_stat.empty) |=> !$isunknown(rd_data))
    else $error("an accepted read returned an unknown word");

endmodule

bind async_fifo async_fifo_chk u_chk (
  .wr_clk   (wr_clk),
  .wr_rst_n (wr_rst_n),
  .rd_clk   (rd_clk),
  .rd_rst_n (rd_rst_n),
  .rd_en    (rd_en),
  .rd_data  (rd_data),
  .wr_stat  (wr_stat),
  .rd_stat  (rd_stat)
);

// File: dv/async_fifo_tb.sv
`timescale 1ns/10ps

module async_fifo_tb;

  import afifo_pkg::*;

  localparam int depth        = 16;
  localparam int afull_level  = 12;
  localparam int aempty_level = 2;
  localparam int wr_per       = 20;
  localparam int rd_per       = 28;
  localparam logic [31:0] lcg_seed = 32'hd2d5_4057;

  // rough length of each test, the watchdog adds a quarter on top
  localparam int settle_ns = 8 * rd_per + wr_per;
  localparam int drain_ns  = (depth + 8) * rd_per;
  localparam int test_ns   = 16 * wr_per + rd_per + 6 * settle_ns
                           + 12 * wr_per + 8 * rd_per + drain_ns
                           + (depth + 6) * wr_per + drain_ns
                           + (depth + 1) * (3 * wr_per + 11 * rd_per) + drain_ns
                           + 3 * wr_per + 16 * rd_per + drain_ns
                           + 401 * wr_per + drain_ns;
  localparam int watchdog_ns = test_ns + test_ns / 4 + 1000;

  logic     wr_clk;
  logic     rd_clk;
  logic     wr_rst_n;
  logic     rd_rst_n;
  logic     wr_en;
  logic     rd_en;
  data_t    wr_data;
  data_t    rd_data;
  wr_stat_t wr_stat;
  rd_stat_t rd_stat;

  data_t       ref_q[$];      // words accepted but not yet read
  logic        rd_pend = 1'b0; // a read was accepted at the last rd_clk negedge
  data_t       rd_exp;
  logic [31:0] wr_lcg = lcg_seed;
  logic [31:0] rd_lcg = lcg_seed;
  int          value_errs = 0;
  int          other_errs = 0;

  tb_clk_gen #(.period_ns(wr_per)) u_wr_clk_gen (.clk(wr_clk));
  tb_clk_gen #(.period_ns(rd_per)) u_rd_clk_gen (.clk(rd_clk));

  async_fifo #(
    .depth        (depth),
    .afull_level  (afull_level),
    .aempty_level (aempty_level)
  ) DUT (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .wr_stat  (wr_stat),
    .rd_stat  (rd_stat)
  );

  // ####################
  // helpers
  // ####################

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic data_t next_word();
    wr_lcg = lcg_next(wr_lcg);
    return wr_lcg[31:24];  // upper bits have the longest period
  endfunction

  task automatic expect_word(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      value_errs++;
      $display("Fail %0t ns: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errs++;
      $display("Fail %0t ns: %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // one wr_clk cycle, driven on the falling edge
  task automatic write_step(input logic en, input data_t d);
    @(negedge wr_clk);
    wr_en   = en;
    wr_data = d;
    if (en && !wr_stat.full) ref_q.push_back(d);  // the DUT sees the same full at the next edge
  endtask

  // one rd_clk cycle, the word of the previous accepted read is checked here
  task automatic read_step(input logic en);
    @(negedge rd_clk);
    if (rd_pend) expect_word("rd_data", rd_exp, rd_data);
    rd_en   = en;
    rd_pend = en && !rd_stat.empty;
    if (rd_pend) begin
      if (ref_q.size() == 0) begin
        other_errs++;
        $display("a read was accepted although no word was written");
        rd_pend = 1'b0;
      end else begin
        rd_exp = ref_q.pop_front();
      end
    end
  endtask

  // both pointers reach the other domain
  task automatic settle();
    repeat (8) @(negedge rd_clk);
    @(negedge wr_clk);
  endtask

  task automatic wait_not_empty();
    int n;
    n = 0;
    @(negedge rd_clk);
    while (rd_stat.empty && n < 6) begin
      @(negedge rd_clk);
      n++;
    end
    if (rd_stat.empty) begin
      other_errs++;
      $display("empty still high 6 rd_clk cycles after a write");
    end
  endtask

  task automatic drain_fifo();
    int n;
    n = 0;
    while (ref_q.size() > 0 && n < 4 * depth + 20) begin
      read_step(1'b1);
      n++;
    end
    read_step(1'b0);  // checks the last word and drops rd_en
    if (ref_q.size() != 0) begin
      other_errs++;
      $display("drain stopped with %0d words still expected", ref_q.size());
    end
    check_flag("rd_stat.empty", 1'b1, rd_stat.empty);
  endtask

  // ####################
  // tests
  // ####################

  task automatic reset_values();
    @(negedge wr_clk);
    check_flag("wr_stat.full", 1'b0, wr_stat.full);
    check_flag("wr_stat.afull", 1'b0, wr_stat.afull);
    @(negedge rd_clk);
    check_flag("rd_stat.empty", 1'b1, rd_stat.empty);
    check_flag("rd_stat.aempty", 1'b1, rd_stat.aempty);
  endtask

  task automatic word_order();
    settle();
    repeat (10) write_step(1'b1, next_word());
    write_step(1'b0, '0);
    wait_not_empty();
    drain_fifo();
  endtask

  task automatic full_and_drop();
    int used;
    settle();
    for (int i = 0; i < depth + 4; i++) begin
      used = ref_q.size();
      write_step(1'b1, next_word());
      check_flag("wr_stat.full", used == depth, wr_stat.full);  // reflects the writes before this one
    end
    write_step(1'b0, '0);
    check_flag("wr_stat.full", 1'b1, wr_stat.full);
    if (ref_q.size() != depth) begin
      value_errs++;
      $display("Fail %0t ns: accepted writes expected %0d actual %0d", $time, depth, ref_q.size());
    end
    drain_fifo();
  endtask

  task automatic flag_thresholds();
    int used;
    settle();
    for (int k = 0; k <= depth; k++) begin
      if (k > 0) begin
        write_step(1'b1, next_word());
        write_step(1'b0, '0);
      end
      repeat (10) @(negedge rd_clk);
      used = ref_q.size();
      check_flag("rd_stat.empty", used == 0, rd_stat.empty);
      check_flag("rd_stat.aempty", used <= aempty_level, rd_stat.aempty);
      @(negedge wr_clk);
      check_flag("wr_stat.full", used == depth, wr_stat.full);
      check_flag("wr_stat.afull", used >= afull_level, wr_stat.afull);
    end
    drain_fifo();
  endtask

  task automatic empty_reads();
    data_t held;
    settle();
    @(negedge rd_clk);
    check_flag("rd_stat.empty", 1'b1, rd_stat.empty);
    held = rd_data;
    repeat (8) begin
      read_step(1'b1);
      expect_word("rd_data", held, rd_data);
      check_flag("rd_stat.empty", 1'b1, rd_stat.empty);
    end
    read_step(1'b0);
    write_step(1'b1, next_word());
    write_step(1'b0, '0);
    wait_not_empty();
    drain_fifo();
  endtask

  task automatic streaming();
    logic wr_done;
    wr_done = 1'b0;
    settle();
    fork
      begin
        repeat (400) begin
          wr_lcg = lcg_next(wr_lcg);
          write_step(wr_lcg[21:20] != 2'b00, wr_lcg[31:24]);
        end
        write_step(1'b0, '0);
        wr_done = 1'b1;
      end
      begin
        while (!wr_done) begin
          rd_lcg = lcg_next(rd_lcg);
          read_step(rd_lcg[19:18] != 2'b00);  // slower than the writer, so full is hit
        end
      end
    join
    drain_fifo();
  endtask

  // ####################
  // run
  // ####################

  initial begin
    wr_en    = 1'b0;
    wr_data  = '0;
    rd_en    = 1'b0;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    repeat (16) @(posedge wr_clk);
    @(negedge wr_clk);
    wr_rst_n = 1'b1;
    @(negedge rd_clk);
    rd_rst_n = 1'b1;

    reset_values();
    word_order();
    full_and_drop();
    flag_thresholds();
    empty_reads();
    streaming();

    $display("errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("timeout, the tests did not finish within %0d ns", watchdog_ns);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: filelist.f
logic/afifo_pkg.sv
logic/afifo_dpram.sv
logic/afifo_gray_sync.sv
logic/afifo_wr_ctrl.sv
logic/afifo_rd_ctrl.sv
logic/async_fifo.sv
dv/tb_clk_gen.sv
dv/async_fifo_chk.sv
dv/async_fifo_tb.sv
